// ==== design/ppu_pkg.sv ====
`default_nettype none

package ppu_pkg;

  // ====================
  // Frame geometry
  // ====================

  // Dots per line and lines per frame
  localparam logic [8:0] DOTS_PER_LINE = 9'd456;
  localparam logic [7:0] LINES_PER_FRAME = 8'd154;
  // Visible area
  localparam logic [7:0] SCREEN_WIDTH = 8'd160;
  localparam logic [7:0] SCREEN_HEIGHT = 8'd144;
  // OAM scan length in dots
  localparam logic [8:0] MODE2_LEN = 9'd80;

  // ====================
  // Address map
  // ====================

  localparam logic [15:0] VRAM_START = 16'h8000;
  localparam logic [15:0] VRAM_END = 16'h9FFF;
  localparam logic [15:0] OAM_START = 16'hFE00;
  localparam logic [15:0] OAM_END = 16'hFE9F;
  localparam logic [15:0] REG_START = 16'hFF40;
  localparam logic [15:0] REG_END = 16'hFF4B;

  // LCD registers inside the register window
  localparam logic [15:0] LCDC_ADDR = 16'hFF40;
  localparam logic [15:0] STAT_ADDR = 16'hFF41;
  localparam logic [15:0] SCY_ADDR = 16'hFF42;
  localparam logic [15:0] SCX_ADDR = 16'hFF43;
  localparam logic [15:0] LY_ADDR = 16'hFF44;
  localparam logic [15:0] LYC_ADDR = 16'hFF45;
  localparam logic [15:0] BGP_ADDR = 16'hFF47;

  // Storage sizes in bytes
  localparam int VRAM_SIZE = 8192;
  localparam int OAM_SIZE = 160;

  // ====================
  // Renderer
  // ====================

  // Pixel FIFO depth in pixels
  localparam int FIFO_DEPTH = 16;

  // Fetcher step codes
  localparam logic [1:0] FETCH_MAP = 2'd0;
  localparam logic [1:0] FETCH_LO = 2'd1;
  localparam logic [1:0] FETCH_HI = 2'd2;
  localparam logic [1:0] FETCH_PUSH = 2'd3;

  // Values match the STAT mode bits
  typedef enum logic [1:0] {
    HBLANK   = 2'd0,
    VBLANK   = 2'd1,
    OAM_SCAN = 2'd2,
    XFER     = 2'd3
  } ppu_mode_t;

  // LCDC seen as a raw byte by the CPU, as flags by the renderer
  typedef union packed {
    logic [7:0] raw;
    struct packed {
      logic       lcd_on;
      logic [1:0] rsvd_hi;
      logic       bg_data_sel;
      logic       bg_map_sel;
      logic [1:0] rsvd_lo;
      logic       bg_on;
    } flags;
  } lcdc_u;

  typedef struct packed {
    lcdc_u      lcdc;
    logic [7:0] scy;
    logic [7:0] scx;
    logic [7:0] lyc;
    logic [7:0] bgp;
    // Same order as STAT bits 6..3
    struct packed {
      logic lyc;
      logic mode2;
      logic mode1;
      logic mode0;
    } stat_en;
  } ppu_cfg_t;

  typedef struct packed {
    logic [7:0] ly;
    ppu_mode_t  mode;
    logic       lyc_match;
  } ppu_status_t;

  typedef struct packed {
    logic [7:0] x;
    logic [7:0] y;
    logic [1:0] shade;
  } pixel_t;

endpackage

`default_nettype wire

// ==== design/ppu_cpu_port.sv ====
`timescale 1ns/10ps
`default_nettype none

module ppu_cpu_port (
  input  logic                clk,
  input  logic                reset,
  input  logic [15:0]         addr,
  input  logic [7:0]          wdata,
  input  logic                write_en,
  input  logic                read_en,
  output logic [7:0]          rdata,
  input  ppu_pkg::ppu_status_t status,
  output ppu_pkg::ppu_cfg_t    cfg,
  input  logic [12:0]         fetch_addr,
  input  logic                fetch_rd,
  output logic [7:0]          fetch_data
);
  import ppu_pkg::*;

  logic [7:0] vram [VRAM_SIZE];
  logic [7:0] oam [OAM_SIZE];

  logic vram_sel;
  logic oam_sel;
  logic reg_sel;
  logic blocked;

  // ====================
  // Address decode
  // ====================
  assign vram_sel = addr inside {[VRAM_START : VRAM_END]};
  assign oam_sel = addr inside {[OAM_START : OAM_END]};
  assign reg_sel = addr inside {[REG_START : REG_END]};

  // CPU locked out of VRAM while pixels are being fetched
  assign blocked = (status.mode == XFER);

  // ====================
  // Register writes
  // ====================
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      cfg <= '0;
    end else if (write_en && reg_sel) begin
      case (addr)
        LCDC_ADDR: cfg.lcdc.raw <= wdata;
        // Only enable bits 6..3 are writable
        STAT_ADDR: cfg.stat_en <= wdata[6:3];
        SCY_ADDR:  cfg.scy <= wdata;
        SCX_ADDR:  cfg.scx <= wdata;
        LYC_ADDR:  cfg.lyc <= wdata;
        BGP_ADDR:  cfg.bgp <= wdata;
        // LY and unmapped slots ignore writes
        default: ;
      endcase
    end
  end

  // ====================
  // Memory writes
  // ====================
  always_ff @(posedge clk) begin
    if (write_en && vram_sel && !blocked) begin
      vram[addr[12:0]] <= wdata;
    end
    // OAM is plain storage here
    if (write_en && oam_sel) begin
      oam[addr[7:0]] <= wdata;
    end
  end

  // Fetcher side of VRAM, always open
  assign fetch_data = fetch_rd ? vram[fetch_addr] : 8'hFF;

  // ====================
  // CPU reads
  // ====================
  always_comb begin
    // Open bus by default
    rdata = 8'hFF;
    if (read_en) begin
      if (vram_sel) begin
        rdata = blocked ? 8'hFF : vram[addr[12:0]];
      end else if (oam_sel) begin
        rdata = oam[addr[7:0]];
      end else if (reg_sel) begin
        case (addr)
          LCDC_ADDR: rdata = cfg.lcdc.raw;
          // Bit 7 reads as 1, low bits are live
          STAT_ADDR: rdata = {1'b1, cfg.stat_en, status.lyc_match, status.mode};
          SCY_ADDR:  rdata = cfg.scy;
          SCX_ADDR:  rdata = cfg.scx;
          LY_ADDR:   rdata = status.ly;
          LYC_ADDR:  rdata = cfg.lyc;
          BGP_ADDR:  rdata = cfg.bgp;
          default:   rdata = 8'hFF;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/ppu_timing.sv ====
`timescale 1ns/10ps
`default_nettype none

module ppu_timing (
  input  logic                 clk,
  input  logic                 reset,
  input  ppu_pkg::ppu_cfg_t    cfg,
  input  logic                 line_done,
  output ppu_pkg::ppu_status_t status,
  output logic                 flush,
  output logic                 vblank_irq,
  output logic                 stat_irq
);
  import ppu_pkg::*;

  logic [8:0] dot;
  logic [7:0] ly;
  logic [7:0] ly_next;
  ppu_mode_t  mode;
  ppu_mode_t  mode_prev;
  logic       lyc_match;
  logic       lyc_match_prev;
  logic       line_end;
  logic       mode_entry;
  logic       lcd_on;

  assign lcd_on = cfg.lcdc.flags.lcd_on;
  assign line_end = (dot == DOTS_PER_LINE - 9'd1);
  // Wrap back to line 0 after the last VBlank line
  assign ly_next = (ly == LINES_PER_FRAME - 8'd1) ? 8'd0 : ly + 8'd1;
  assign lyc_match = (ly == cfg.lyc);
  assign mode_entry = (mode != mode_prev);

  always_comb begin
    status.ly = ly;
    status.mode = mode;
    status.lyc_match = lyc_match;
  end

  // ====================
  // Dots, lines, modes
  // ====================
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      dot <= '0;
      ly <= '0;
      mode <= OAM_SCAN;
      flush <= 1'b0;
    end else begin
      flush <= 1'b0;
      if (!lcd_on) begin
        // Display off, park at start of frame
        dot <= '0;
        ly <= '0;
        mode <= OAM_SCAN;
        // Drop any half-done line
        flush <= (mode == XFER);
      end else if (line_end) begin
        dot <= '0;
        ly <= ly_next;
        mode <= (ly_next >= SCREEN_HEIGHT) ? VBLANK : OAM_SCAN;
      end else begin
        dot <= dot + 9'd1;
        case (mode)
          // Fixed-length scan, then transfer from dot 80
          OAM_SCAN: if (dot == MODE2_LEN - 9'd1) mode <= XFER;
          // Variable length, ends on the last pixel
          XFER: begin
            if (line_done) begin
              mode <= HBLANK;
              flush <= 1'b1;
            end
          end
          // HBlank and VBlank wait for the line wrap
          default: ;
        endcase
      end
    end
  end

  // ====================
  // Interrupt pulses
  // ====================
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      mode_prev <= OAM_SCAN;
      lyc_match_prev <= 1'b0;
      vblank_irq <= 1'b0;
      stat_irq <= 1'b0;
    end else begin
      mode_prev <= mode;
      lyc_match_prev <= lyc_match;
      // One cycle after LY reaches 144
      vblank_irq <= mode_entry && (mode == VBLANK);
      stat_irq <= 1'b0;
      if (lcd_on) begin
        // LYC coincidence wins over mode events
        if (cfg.stat_en.lyc && lyc_match && !lyc_match_prev) begin
          stat_irq <= 1'b1;
        end else if (mode_entry) begin
          case (mode)
            OAM_SCAN: stat_irq <= cfg.stat_en.mode2;
            VBLANK:   stat_irq <= cfg.stat_en.mode1;
            HBLANK:   stat_irq <= cfg.stat_en.mode0;
            default:  stat_irq <= 1'b0;
          endcase
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/bg_fetcher.sv ====
`timescale 1ns/10ps
`default_nettype none

module bg_fetcher (
  input  logic                 clk,
  input  logic                 reset,
  input  ppu_pkg::ppu_cfg_t    cfg,
  input  ppu_pkg::ppu_status_t status,
  input  logic                 flush,
  output logic [12:0]          fetch_addr,
  output logic                 fetch_rd,
  input  logic [7:0]           fetch_data,
  input  logic                 fifo_room,
  output logic                 push,
  output logic [15:0]          push_px
);
  import ppu_pkg::*;

  logic [1:0] step;
  // Tiles fetched so far on this line
  logic [4:0] tile_n;
  logic [7:0] tile_idx;
  logic [7:0] lo_byte;
  logic [7:0] hi_byte;

  logic       in_xfer;
  logic [7:0] bg_y;
  logic [4:0] tile_col;
  logic       data_bank;

  assign in_xfer = (status.mode == XFER);

  // Background row and column, both wrap at 256 pixels
  assign bg_y = status.ly + cfg.scy;
  assign tile_col = cfg.scx[7:3] + tile_n;

  // Bit 12 of the data address
  // Signed mode puts tiles 0..127 at 1000, 128..255 at 0800
  assign data_bank = ~(cfg.lcdc.flags.bg_data_sel | tile_idx[7]);

  // ====================
  // VRAM address
  // ====================
  always_comb begin
    fetch_rd = in_xfer && (step != FETCH_PUSH);
    case (step)
      // Map at 1800 or 1C00, 32 tiles per row
      FETCH_MAP: fetch_addr = {2'b11, cfg.lcdc.flags.bg_map_sel, bg_y[7:3], tile_col};
      // 16 bytes per tile, 2 per row
      FETCH_LO:  fetch_addr = {data_bank, tile_idx, bg_y[2:0], 1'b0};
      default:   fetch_addr = {data_bank, tile_idx, bg_y[2:0], 1'b1};
    endcase
  end

  assign push = in_xfer && (step == FETCH_PUSH) && fifo_room;

  // Leftmost pixel in slot 0, taken from bit 7
  always_comb begin
    for (int i = 0; i < 8; i++) begin
      push_px[2*i +: 2] = {hi_byte[7-i], lo_byte[7-i]};
    end
  end

  // ====================
  // Step sequencer
  // ====================
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      step <= FETCH_MAP;
      tile_n <= '0;
    end else if (flush) begin
      step <= FETCH_MAP;
      tile_n <= '0;
    end else if (in_xfer) begin
      case (step)
        FETCH_MAP: step <= FETCH_LO;
        FETCH_LO:  step <= FETCH_HI;
        FETCH_HI:  step <= FETCH_PUSH;
        default: begin
          // Stall here until the FIFO can take 8 more
          if (fifo_room) begin
            step <= FETCH_MAP;
            tile_n <= tile_n + 5'd1;
          end
        end
      endcase
    end
  end

  // Fetched bytes
  always_ff @(posedge clk) begin
    if (in_xfer) begin
      case (step)
        FETCH_MAP: tile_idx <= fetch_data;
        FETCH_LO:  lo_byte <= fetch_data;
        FETCH_HI:  hi_byte <= fetch_data;
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== design/pixel_out.sv ====
`timescale 1ns/10ps
`default_nettype none

module pixel_out (
  input  logic                 clk,
  input  logic                 reset,
  input  ppu_pkg::ppu_cfg_t    cfg,
  input  ppu_pkg::ppu_status_t status,
  input  logic                 flush,
  input  logic                 push,
  input  logic [15:0]          push_px,
  output logic                 fifo_room,
  output ppu_pkg::pixel_t      pixel,
  output logic                 pixel_valid,
  output logic                 line_done
);
  import ppu_pkg::*;

  // ====================
  // Pixel FIFO
  // ====================
  logic [1:0] fifo_mem [FIFO_DEPTH];
  logic [3:0] wr_ptr;
  logic [3:0] rd_ptr;
  logic [4:0] count;

  logic [2:0] disc_cnt;
  logic [7:0] x_cnt;
  logic       pop;
  logic       discard;
  logic [1:0] head;
  logic [1:0] shade;

  // Room for a whole tile
  assign fifo_room = (count <= 5'(FIFO_DEPTH - 8));

  // Pop while transferring, until 160 pixels are out
  assign pop = (status.mode == XFER) && (count != 5'd0) && (x_cnt < SCREEN_WIDTH);
  // Fine scroll, drop the first SCX mod 8 pixels
  assign discard = (disc_cnt < cfg.scx[2:0]);

  assign head = fifo_mem[rd_ptr];
  // Palette lookup, BG off shows color 0
  assign shade = cfg.lcdc.flags.bg_on ? cfg.bgp[{head, 1'b0} +: 2] : cfg.bgp[1:0];

  always_ff @(posedge clk) begin
    if (push) begin
      for (int i = 0; i < 8; i++) begin
        fifo_mem[wr_ptr + 4'(i)] <= push_px[2*i +: 2];
      end
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
      disc_cnt <= '0;
      x_cnt <= '0;
    end else if (flush) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
      disc_cnt <= '0;
      x_cnt <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 4'd8;
      if (pop) rd_ptr <= rd_ptr + 4'd1;
      count <= count + (push ? 5'd8 : 5'd0) - (pop ? 5'd1 : 5'd0);
      if (pop && discard) begin
        disc_cnt <= disc_cnt + 3'd1;
      end else if (pop) begin
        x_cnt <= x_cnt + 8'd1;
      end
    end
  end

  // ====================
  // Output stage
  // ====================
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pixel_valid <= 1'b0;
      line_done <= 1'b0;
    end else begin
      pixel_valid <= pop && !discard;
      // Comes with the last pixel of the line
      line_done <= pop && !discard && (x_cnt == SCREEN_WIDTH - 8'd1);
    end
  end

  always_ff @(posedge clk) begin
    if (pop && !discard) begin
      pixel.x <= x_cnt;
      pixel.y <= status.ly;
      pixel.shade <= shade;
    end
  end

endmodule

`default_nettype wire

// ==== design/ppu_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module ppu_top (
  input  logic            clk,
  input  logic            reset,
  input  logic [15:0]     addr,
  input  logic [7:0]      wdata,
  input  logic            write_en,
  input  logic            read_en,
  output logic [7:0]      rdata,
  output ppu_pkg::pixel_t pixel,
  output logic            pixel_valid,
  output logic            vblank_irq,
  output logic            stat_irq
);
  import ppu_pkg::*;

  ppu_cfg_t    cfg;
  ppu_status_t status;

  // Fetcher VRAM port
  logic [12:0] fetch_addr;
  logic        fetch_rd;
  logic [7:0]  fetch_data;

  // Fetcher to pixel output
  logic        push;
  logic [15:0] push_px;
  logic        fifo_room;

  // Line control
  logic        line_done;
  logic        flush;

  ppu_cpu_port u_cpu_port (
    .clk        (clk),
    .reset      (reset),
    .addr       (addr),
    .wdata      (wdata),
    .write_en   (write_en),
    .read_en    (read_en),
    .rdata      (rdata),
    .status     (status),
    .cfg        (cfg),
    .fetch_addr (fetch_addr),
    .fetch_rd   (fetch_rd),
    .fetch_data (fetch_data)
  );

  ppu_timing u_timing (
    .clk        (clk),
    .reset      (reset),
    .cfg        (cfg),
    .line_done  (line_done),
    .status     (status),
    .flush      (flush),
    .vblank_irq (vblank_irq),
    .stat_irq   (stat_irq)
  );

  bg_fetcher u_fetcher (
    .clk        (clk),
    .reset      (reset),
    .cfg        (cfg),
    .status     (status),
    .flush      (flush),
    .fetch_addr (fetch_addr),
    .fetch_rd   (fetch_rd),
    .fetch_data (fetch_data),
    .fifo_room  (fifo_room),
    .push       (push),
    .push_px    (push_px)
  );

  pixel_out u_pixel_out (
    .clk         (clk),
    .reset       (reset),
    .cfg         (cfg),
    .status      (status),
    .flush       (flush),
    .push        (push),
    .push_px     (push_px),
    .fifo_room   (fifo_room),
    .pixel       (pixel),
    .pixel_valid (pixel_valid),
    .line_done   (line_done)
  );

endmodule

`default_nettype wire

// ==== tb/ppu_sva.sv ====
`timescale 1ns/10ps
`default_nettype none

module ppu_sva (
  input  logic                 clk,
  input  logic                 reset,
  input  ppu_pkg::ppu_status_t status,
  input  logic                 line_done,
  input  logic                 vblank_irq,
  input  logic                 stat_irq
);
  import ppu_pkg::*;

  // Interrupts are single-cycle pulses
  vblank_single: assert property (@(posedge clk) disable iff (reset)
    vblank_irq |=> !vblank_irq)
    else $error("vblank_irq held high for two cycles");

  stat_single: assert property (@(posedge clk) disable iff (reset)
    stat_irq |=> !stat_irq)
    else $error("stat_irq held high for two cycles");

  // Last pixel ends the transfer
  xfer_end: assert property (@(posedge clk) disable iff (reset)
    line_done |=> (status.mode == HBLANK))
    else $error("mode is not HBLANK after line_done");

  // Line counter range
  ly_range: assert property (@(posedge clk) disable iff (reset)
    status.ly < LINES_PER_FRAME)
    else $error("LY reached 154 or more");

endmodule

`default_nettype wire

// ==== tb/ppu_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module ppu_tb;
  import ppu_pkg::*;

  typedef struct packed {
    logic        is_read;
    logic [15:0] addr;
    logic [7:0]  data;
    logic [7:0]  exp;
  } bus_op_t;

  localparam int TABLE_LEN = 30;
  localparam int FRAME_CYCLES = 70224;
  // Fill, table, three short pixel runs and six frames of timing checks
  localparam int MAX_CYCLES = 7 * FRAME_CYCLES + 4 * VRAM_SIZE + 4 * TABLE_LEN + 3 * 12 * 456;

  logic        clk;
  logic        reset;
  logic [15:0] addr;
  logic [7:0]  wdata;
  logic        write_en;
  logic        read_en;
  logic [7:0]  rdata;
  pixel_t      pixel;
  logic        pixel_valid;
  logic        vblank_irq;
  logic        stat_irq;

  int check_cnt = 0;
  int error_cnt = 0;
  int cycle_cnt = 0;
  int vblank_cnt = 0;
  int stat_cnt = 0;
  int last_stamp = 0;
  int prev_stamp = 0;
  // Pixels seen since the LCD went on, in raster order
  int px_seen = 0;
  logic capture = 1'b0;

  // Mirror of accepted VRAM writes and of the render registers
  logic [7:0] vram_model [VRAM_SIZE];
  lcdc_u      cur_lcdc;
  logic [7:0] cur_scx;
  logic [7:0] cur_scy;
  logic [7:0] cur_bgp;
  logic [31:0] lfsr = 32'h097326e8;

  // Register checks, then storage with the LCD off
  bus_op_t op_table [TABLE_LEN] = '{
    '{1'b0, 16'hFF40, 8'h00, 8'h00}, '{1'b0, 16'hFF42, 8'h5A, 8'h00},
    '{1'b1, 16'hFF42, 8'h00, 8'h5A}, '{1'b0, 16'hFF43, 8'hC3, 8'h00},
    '{1'b1, 16'hFF43, 8'h00, 8'hC3}, '{1'b0, 16'hFF45, 8'h77, 8'h00},
    '{1'b1, 16'hFF45, 8'h00, 8'h77}, '{1'b0, 16'hFF47, 8'hE4, 8'h00},
    '{1'b1, 16'hFF47, 8'h00, 8'hE4}, '{1'b0, 16'hFF41, 8'hFF, 8'h00},
    '{1'b1, 16'hFF41, 8'h00, 8'hFA}, '{1'b0, 16'hFF41, 8'h00, 8'h00},
    '{1'b1, 16'hFF41, 8'h00, 8'h82}, '{1'b0, 16'hFF44, 8'h55, 8'h00},
    '{1'b1, 16'hFF44, 8'h00, 8'h00}, '{1'b1, 16'hFF46, 8'h00, 8'hFF},
    '{1'b1, 16'hFF48, 8'h00, 8'hFF}, '{1'b1, 16'hFF4C, 8'h00, 8'hFF},
    '{1'b0, 16'hFF40, 8'h91, 8'h00}, '{1'b1, 16'hFF40, 8'h00, 8'h91},
    '{1'b0, 16'hFF40, 8'h00, 8'h00}, '{1'b0, 16'h8000, 8'h3C, 8'h00},
    '{1'b1, 16'h8000, 8'h00, 8'h3C}, '{1'b0, 16'h9FFF, 8'hA5, 8'h00},
    '{1'b1, 16'h9FFF, 8'h00, 8'hA5}, '{1'b0, 16'hFE00, 8'h11, 8'h00},
    '{1'b1, 16'hFE00, 8'h00, 8'h11}, '{1'b0, 16'hFE9F, 8'h22, 8'h00},
    '{1'b1, 16'hFE9F, 8'h00, 8'h22}, '{1'b0, 16'hFF45, 8'h00, 8'h00}
  };

  ppu_top uut (
    .clk         (clk),
    .reset       (reset),
    .addr        (addr),
    .wdata       (wdata),
    .write_en    (write_en),
    .read_en     (read_en),
    .rdata       (rdata),
    .pixel       (pixel),
    .pixel_valid (pixel_valid),
    .vblank_irq  (vblank_irq),
    .stat_irq    (stat_irq)
  );

  bind ppu_timing ppu_sva timing_checks (
    .clk        (clk),
    .reset      (reset),
    .status     (status),
    .line_done  (line_done),
    .vblank_irq (vblank_irq),
    .stat_irq   (stat_irq)
  );

  // 8 ns clock
  initial clk = 1'b0;
  always #4 clk = ~clk;

  // ====================
  // Compare tasks
  // ====================
  task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
    check_cnt++;
    if (act !== exp) begin
      error_cnt++;
      $display("** Error %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_pixel(input pixel_t exp, input pixel_t act);
    check_cnt++;
    if (act !== exp) begin
      error_cnt++;
      $display("** Error pixel: expected %h, actual %h", exp, act);
    end
  endtask

  task automatic check_pulse(input string name, input int exp, input int act);
    check_cnt++;
    if (act != exp) begin
      error_cnt++;
      $display("** Error %s pulse count: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    check_cnt++;
    if (act != exp) begin
      error_cnt++;
      $display("** Error %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  // ====================
  // Stimulus helpers
  // ====================
  // Galois LFSR, taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) n = n ^ 32'h80200003;
    return n;
  endfunction

  task automatic random_byte(output logic [7:0] b);
    b = 8'h00;
    for (int i = 0; i < 8; i++) begin
      b = {b[6:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
  endtask

  task automatic bus_write(input logic [15:0] a, input logic [7:0] d);
    @(posedge clk);
    #1;
    addr = a;
    wdata = d;
    read_en = 1'b0;
    write_en = 1'b1;
    @(posedge clk);
    #1;
    write_en = 1'b0;
  endtask

  // Combinational read, sampled mid-cycle
  task automatic bus_read(input logic [15:0] a, output logic [7:0] d);
    @(posedge clk);
    #1;
    addr = a;
    read_en = 1'b1;
    #2;
    d = rdata;
  endtask

  task automatic wait_vblanks(input int n);
    int target;
    target = vblank_cnt + n;
    while (vblank_cnt < target) @(negedge clk);
    #1;
  endtask

  // Poll STAT until the first cycle of a transfer
  task automatic wait_xfer();
    logic [7:0] d;
    bus_read(STAT_ADDR, d);
    while (d[1:0] == 2'd3) bus_read(STAT_ADDR, d);
    while (d[1:0] != 2'd3) bus_read(STAT_ADDR, d);
  endtask

  // Background pixel at screen (x, y) from the VRAM mirror
  function automatic logic [1:0] ref_shade(input logic [7:0] x, input logic [7:0] y);
    logic [7:0] bx;
    logic [7:0] by;
    logic [7:0] idx;
    logic [7:0] lo;
    logic [7:0] hi;
    logic [1:0] color;
    int map_a;
    int tile_a;
    int bitn;
    bx = x + cur_scx;
    by = y + cur_scy;
    map_a = (cur_lcdc.flags.bg_map_sel ? 32'h1C00 : 32'h1800);
    map_a = map_a + 32 * int'(by[7:3]) + int'(bx[7:3]);
    idx = vram_model[map_a];
    if (cur_lcdc.flags.bg_data_sel) tile_a = 16 * int'(idx);
    else tile_a = 4096 + 16 * int'($signed(idx));
    tile_a = tile_a + 2 * int'(by[2:0]);
    lo = vram_model[tile_a];
    hi = vram_model[tile_a + 1];
    bitn = 7 - int'(bx[2:0]);
    color = {hi[bitn], lo[bitn]};
    if (!cur_lcdc.flags.bg_on) return cur_bgp[1:0];
    return cur_bgp[2 * int'(color) +: 2];
  endfunction

  // Eight lines with one scroll and palette setup
  task automatic run_pixels(input logic [7:0] lcdc, input logic [7:0] scy,
                            input logic [7:0] scx, input logic [7:0] bgp);
    logic [7:0] d;
    bus_write(LCDC_ADDR, 8'h00);
    bus_write(SCY_ADDR, scy);
    bus_write(SCX_ADDR, scx);
    bus_write(BGP_ADDR, bgp);
    cur_lcdc = lcdc;
    cur_scy = scy;
    cur_scx = scx;
    cur_bgp = bgp;
    px_seen = 0;
    capture = 1'b1;
    bus_write(LCDC_ADDR, lcdc);
    bus_read(LY_ADDR, d);
    while (d < 8'd8) bus_read(LY_ADDR, d);
    capture = 1'b0;
    bus_write(LCDC_ADDR, 8'h00);
    // 160 pixels on each of lines 0..7
    check_count("pixels on lines 0 to 7", 8 * 160, px_seen);
  endtask

  // ====================
  // Monitors
  // ====================
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("test failed");
      $finish;
    end
  end

  // Outputs settle after the rising edge, sample on the falling one
  always @(negedge clk) begin
    pixel_t exp;
    if (!reset) begin
      if (vblank_irq) begin
        vblank_cnt++;
        prev_stamp = last_stamp;
        last_stamp = cycle_cnt;
      end
      if (stat_irq) stat_cnt++;
      // Raster order from line 0, x running 0..159
      if (pixel_valid && capture) begin
        exp.x = 8'(px_seen % 160);
        exp.y = 8'(px_seen / 160);
        exp.shade = ref_shade(exp.x, exp.y);
        check_pixel(exp, pixel);
        px_seen++;
      end
    end
  end

  // ====================
  // Main sequence
  // ====================
  initial begin
    logic [7:0] d;
    logic [7:0] b;
    int s0;
    int seen_cnt;
    logic seen [256];
    reset = 1'b1;
    addr = 16'h0000;
    wdata = 8'h00;
    write_en = 1'b0;
    read_en = 1'b0;
    repeat (2) @(posedge clk);
    #1;
    reset = 1'b0;

    // Register and storage table
    for (int i = 0; i < TABLE_LEN; i++) begin
      if (op_table[i].is_read) begin
        bus_read(op_table[i].addr, d);
        check_byte($sformatf("rdata @%h", op_table[i].addr), op_table[i].exp, d);
      end else begin
        bus_write(op_table[i].addr, op_table[i].data);
        if (op_table[i].addr inside {[VRAM_START : VRAM_END]}) begin
          vram_model[op_table[i].addr[12:0]] = op_table[i].data;
        end
      end
    end

    // Random VRAM image with the LCD off
    for (int i = 0; i < VRAM_SIZE; i++) begin
      random_byte(b);
      bus_write(VRAM_START + 16'(i), b);
      vram_model[i] = b;
    end

    // CPU locked out during transfer
    bus_write(LCDC_ADDR, 8'h91);
    wait_xfer();
    bus_read(16'h8123, d);
    check_byte("rdata in XFER", 8'hFF, d);
    bus_write(16'h8123, ~vram_model[13'h0123]);
    bus_write(LCDC_ADDR, 8'h00);
    bus_read(16'h8123, d);
    check_byte("rdata after blocked write", vram_model[13'h0123], d);

    // Both data modes, both maps, fine scroll
    run_pixels(8'h91, 8'h00, 8'h00, 8'hE4);
    run_pixels(8'h81, 8'h05, 8'h10, 8'h1B);
    run_pixels(8'h99, 8'h83, 8'h1D, 8'h93);

    // Frame timing
    bus_write(LCDC_ADDR, 8'h91);
    wait_vblanks(1);
    bus_read(LY_ADDR, d);
    check_byte("LY after vblank_irq", 8'd144, d);
    for (int i = 0; i < 256; i++) seen[i] = 1'b0;
    s0 = vblank_cnt + 1;
    while (vblank_cnt < s0) begin
      bus_read(LY_ADDR, d);
      seen[d] = 1'b1;
    end
    seen_cnt = 0;
    for (int i = 0; i < 154; i++) if (seen[i]) seen_cnt++;
    for (int i = 154; i < 256; i++) if (seen[i]) seen_cnt += 1000;
    check_count("LY values seen", 154, seen_cnt);
    check_count("vblank_irq spacing", FRAME_CYCLES, last_stamp - prev_stamp);

    // LYC coincidence interrupt
    bus_write(LYC_ADDR, 8'd10);
    bus_write(STAT_ADDR, 8'h40);
    wait_vblanks(1);
    s0 = stat_cnt;
    bus_read(LY_ADDR, d);
    while (stat_cnt == s0) bus_read(LY_ADDR, d);
    bus_read(LY_ADDR, d);
    check_byte("LY at LYC stat_irq", 8'd10, d);
    wait_vblanks(1);
    check_pulse("stat_irq lyc", 1, stat_cnt - s0);

    // HBlank interrupt on every visible line
    bus_write(STAT_ADDR, 8'h08);
    wait_vblanks(1);
    s0 = stat_cnt;
    wait_vblanks(1);
    check_pulse("stat_irq mode0", 144, stat_cnt - s0);
    bus_write(LCDC_ADDR, 8'h00);

    $display("Checks: %0d, errors: %0d", check_cnt, error_cnt);
    if (error_cnt == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== ppu.f ====
design/ppu_pkg.sv
design/ppu_cpu_port.sv
design/ppu_timing.sv
design/bg_fetcher.sv
design/pixel_out.sv
design/ppu_top.sv
tb/ppu_sva.sv
tb/ppu_tb.sv

// ==== Makefile ====
TOP := ppu_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f ppu.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f ppu.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir
